// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W = 32;  // operand and memory data width
    localparam int ADDR_W = 32;
    localparam int BYTES_PER_WORD = DATA_W / 8;

    // operand size, same encoding as the decode stage
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2
    } opsize_e;

    // where an operand comes from
    typedef enum logic [2:0] {
        SEL_REG  = 3'd0,
        SEL_MEM1 = 3'd1,
        SEL_MEM2 = 3'd2,
        SEL_IMM  = 3'd3,
        SEL_EIP  = 3'd4
    } opnd_sel_e;

    // bytes touched by one access of the given size
    function automatic logic [2:0] opsize_bytes(input opsize_e sz);
        case (sz)
            SZ_BYTE:  return 3'd1;
            SZ_WORD:  return 3'd2;
            SZ_DWORD: return 3'd4;
            default:  return 3'd0;  // encoding 3 unused
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data memory geometry
    localparam int MEM_IDX_W = 8;
    localparam int MEM_BYTES = 1 << MEM_IDX_W;  // addresses wrap at this size

    // cycles from access strobe to read data
    localparam int RD_LAT = 1;

    // cycles from instruction strobe to the first result
    // address gen + array read + operand register
    localparam int STAGE_LAT = 3;

endpackage

`default_nettype wire

// File: design/rep_addr_gen.sv
`default_nettype none

module rep_addr_gen import core_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              valid_i,
    input  wire opsize_e           opsize_i,
    input  wire logic              df_i,       // 1 = decrement
    input  wire logic              is_rep_i,
    input  wire logic [ADDR_W-1:0] rep_cnt_i,
    input  wire logic [ADDR_W-1:0] mem_addr1_i,
    input  wire logic [ADDR_W-1:0] mem_addr2_i,
    input  wire logic [DATA_W-1:0] reg_val_i,
    input  wire logic [DATA_W-1:0] imm_i,
    input  wire logic [DATA_W-1:0] eip_i,
    input  wire opnd_sel_e         op1_sel_i,
    input  wire opnd_sel_e         op2_sel_i,
    output logic                   busy_o,
    output logic                   acc_valid_o,
    output logic [ADDR_W-1:0]      acc_addr1_o,
    output logic [ADDR_W-1:0]      acc_addr2_o,
    output opsize_e                acc_size_o,
    output logic                   acc_last_o,
    output logic [DATA_W-1:0]      acc_reg_o,
    output logic [DATA_W-1:0]      acc_imm_o,
    output logic [DATA_W-1:0]      acc_eip_o,
    output opnd_sel_e              acc_sel1_o,
    output opnd_sel_e              acc_sel2_o
);

    logic [ADDR_W-1:0] step_in;
    logic [ADDR_W-1:0] step_q;
    logic [ADDR_W-1:0] next_addr1_q;
    logic [ADDR_W-1:0] next_addr2_q;
    logic [ADDR_W-1:0] cnt_q;        // accesses still to issue
    logic              cnt_nz;
    logic              multi_q;      // repeat with more than one element

    // signed step, two's complement for the down direction
    assign step_in = df_i ? -ADDR_W'(opsize_bytes(opsize_i))
                          :  ADDR_W'(opsize_bytes(opsize_i));

    assign cnt_nz = (cnt_q != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_valid_o <= 1'b0;
            acc_last_o  <= 1'b0;
            cnt_q       <= '0;
            multi_q     <= 1'b0;
        end else if (valid_i) begin
            // a zero count repeat issues nothing
            acc_valid_o <= !is_rep_i || (rep_cnt_i != '0);
            acc_last_o  <= !is_rep_i || (rep_cnt_i == ADDR_W'(1));
            cnt_q       <= (is_rep_i && rep_cnt_i != '0) ? rep_cnt_i - ADDR_W'(1) : '0;
            multi_q     <= is_rep_i && (rep_cnt_i > ADDR_W'(1));
        end else if (cnt_nz) begin
            acc_valid_o <= 1'b1;
            acc_last_o  <= (cnt_q == ADDR_W'(1));
            cnt_q       <= cnt_q - ADDR_W'(1);
        end else begin
            acc_valid_o <= 1'b0;
            acc_last_o  <= 1'b0;
            multi_q     <= 1'b0;
        end
    end

    // addresses and instruction fields
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            acc_addr1_o  <= mem_addr1_i;
            acc_addr2_o  <= mem_addr2_i;
            next_addr1_q <= mem_addr1_i + step_in;
            next_addr2_q <= mem_addr2_i + step_in;
            step_q       <= step_in;
            acc_size_o   <= opsize_i;
            acc_reg_o    <= reg_val_i;
            acc_imm_o    <= imm_i;
            acc_eip_o    <= eip_i;
            acc_sel1_o   <= op1_sel_i;
            acc_sel2_o   <= op2_sel_i;
        end else if (cnt_nz) begin
            acc_addr1_o  <= next_addr1_q;
            acc_addr2_o  <= next_addr2_q;
            next_addr1_q <= next_addr1_q + step_q;
            next_addr2_q <= next_addr2_q + step_q;
        end
    end

    // stall upstream for the whole issue of a multi element repeat
    assign busy_o = acc_valid_o & multi_q;

endmodule

`default_nettype wire

// File: design/dmem_array.sv
`default_nettype none

module dmem_array import core_pkg::*, mem_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              acc_valid_i,
    input  wire logic [ADDR_W-1:0] acc_addr1_i,
    input  wire logic [ADDR_W-1:0] acc_addr2_i,
    input  wire opsize_e           acc_size_i,
    input  wire logic              wb_valid_i,
    input  wire logic [ADDR_W-1:0] wb_addr_i,
    input  wire logic [DATA_W-1:0] wb_data_i,
    input  wire opsize_e           wb_size_i,
    output logic                   rd_valid_o,
    output logic [DATA_W-1:0]      rd_data1_o,
    output logic [DATA_W-1:0]      rd_data2_o
);

    logic [7:0] mem [MEM_BYTES];

    logic [MEM_IDX_W-1:0] wb_idx;

    assign wb_idx = wb_addr_i[MEM_IDX_W-1:0];

    // little endian gather from addr upward, zero extended
    function automatic logic [DATA_W-1:0] read_bytes(
        input logic [ADDR_W-1:0] addr,
        input opsize_e           sz
    );
        logic [DATA_W-1:0]    data;
        logic [MEM_IDX_W-1:0] idx;
        data = '0;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            idx = addr[MEM_IDX_W-1:0] + MEM_IDX_W'(b);  // wraps past the top
            if (b < int'(opsize_bytes(sz))) begin
                data[8*b +: 8] = mem[idx];
            end
        end
        return data;
    endfunction

    // write port, low bytes of wb_data_i only
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (wb_valid_i && b < int'(opsize_bytes(wb_size_i))) begin
                mem[wb_idx + MEM_IDX_W'(b)] <= wb_data_i[8*b +: 8];
            end
        end
    end

    // both read ports see the array before this cycle's write
    always_ff @(posedge clk_i) begin
        if (acc_valid_i) begin
            rd_data1_o <= read_bytes(acc_addr1_i, acc_size_i);
            rd_data2_o <= read_bytes(acc_addr2_i, acc_size_i);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= acc_valid_i;
        end
    end

endmodule

`default_nettype wire

// File: design/operand_select.sv
`default_nettype none

module operand_select import core_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              acc_valid_i,
    input  wire logic              acc_last_i,
    input  wire logic [ADDR_W-1:0] acc_addr1_i,
    input  wire logic [DATA_W-1:0] acc_reg_i,
    input  wire logic [DATA_W-1:0] acc_imm_i,
    input  wire logic [DATA_W-1:0] acc_eip_i,
    input  wire opnd_sel_e         acc_sel1_i,
    input  wire opnd_sel_e         acc_sel2_i,
    input  wire logic              rd_valid_i,
    input  wire logic [DATA_W-1:0] rd_data1_i,
    input  wire logic [DATA_W-1:0] rd_data2_i,
    output logic                   valid_o,
    output logic [DATA_W-1:0]      op1_val_o,
    output logic [DATA_W-1:0]      op2_val_o,
    output logic [ADDR_W-1:0]      dest_addr_o,
    output logic                   last_o
);

    // access fields, one cycle behind to meet the read data
    logic              last_d;
    logic [ADDR_W-1:0] addr1_d;
    logic [DATA_W-1:0] reg_d;
    logic [DATA_W-1:0] imm_d;
    logic [DATA_W-1:0] eip_d;
    opnd_sel_e         sel1_d;
    opnd_sel_e         sel2_d;

    function automatic logic [DATA_W-1:0] pick(
        input opnd_sel_e         sel,
        input logic [DATA_W-1:0] reg_val,
        input logic [DATA_W-1:0] mem1,
        input logic [DATA_W-1:0] mem2,
        input logic [DATA_W-1:0] imm,
        input logic [DATA_W-1:0] eip
    );
        case (sel)
            SEL_REG:  return reg_val;
            SEL_MEM1: return mem1;
            SEL_MEM2: return mem2;
            SEL_IMM:  return imm;
            SEL_EIP:  return eip;
            default:  return '0;
        endcase
    endfunction

    always_ff @(posedge clk_i) begin
        if (acc_valid_i) begin
            last_d  <= acc_last_i;
            addr1_d <= acc_addr1_i;
            reg_d   <= acc_reg_i;
            imm_d   <= acc_imm_i;
            eip_d   <= acc_eip_i;
            sel1_d  <= acc_sel1_i;
            sel2_d  <= acc_sel2_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_valid_i) begin
            op1_val_o   <= pick(sel1_d, reg_d, rd_data1_i, rd_data2_i, imm_d, eip_d);
            op2_val_o   <= pick(sel2_d, reg_d, rd_data1_i, rd_data2_i, imm_d, eip_d);
            dest_addr_o <= addr1_d;  // destination follows the first string address
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_o <= rd_valid_i;
            last_o  <= rd_valid_i & last_d;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage_top.sv
`default_nettype none

module mem_stage_top import core_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              valid_i,
    input  wire opsize_e           opsize_i,
    input  wire logic              df_i,
    input  wire logic              is_rep_i,
    input  wire logic [ADDR_W-1:0] rep_cnt_i,
    input  wire logic [ADDR_W-1:0] mem_addr1_i,
    input  wire logic [ADDR_W-1:0] mem_addr2_i,
    input  wire logic [DATA_W-1:0] reg_val_i,
    input  wire logic [DATA_W-1:0] imm_i,
    input  wire logic [DATA_W-1:0] eip_i,
    input  wire opnd_sel_e         op1_sel_i,
    input  wire opnd_sel_e         op2_sel_i,
    input  wire logic              wb_valid_i,
    input  wire logic [ADDR_W-1:0] wb_addr_i,
    input  wire logic [DATA_W-1:0] wb_data_i,
    input  wire opsize_e           wb_size_i,
    output logic                   busy_o,
    output logic                   valid_o,
    output logic [DATA_W-1:0]      op1_val_o,
    output logic [DATA_W-1:0]      op2_val_o,
    output logic [ADDR_W-1:0]      dest_addr_o,
    output logic                   last_o
);

    logic              acc_valid;
    logic [ADDR_W-1:0] acc_addr1;
    logic [ADDR_W-1:0] acc_addr2;
    opsize_e           acc_size;
    logic              acc_last;
    logic [DATA_W-1:0] acc_reg;
    logic [DATA_W-1:0] acc_imm;
    logic [DATA_W-1:0] acc_eip;
    opnd_sel_e         acc_sel1;
    opnd_sel_e         acc_sel2;

    logic              rd_valid;
    logic [DATA_W-1:0] rd_data1;
    logic [DATA_W-1:0] rd_data2;

    rep_addr_gen u_rep_addr_gen (
        .clk_i, .arst_n_i, .valid_i, .opsize_i, .df_i, .is_rep_i, .rep_cnt_i,
        .mem_addr1_i, .mem_addr2_i, .reg_val_i, .imm_i, .eip_i, .op1_sel_i, .op2_sel_i,
        .busy_o,
        .acc_valid_o (acc_valid), .acc_addr1_o (acc_addr1), .acc_addr2_o (acc_addr2),
        .acc_size_o  (acc_size),  .acc_last_o  (acc_last),  .acc_reg_o   (acc_reg),
        .acc_imm_o   (acc_imm),   .acc_eip_o   (acc_eip),
        .acc_sel1_o  (acc_sel1),  .acc_sel2_o  (acc_sel2)
    );

    // one cycle read, writeback lands straight from outside
    dmem_array u_dmem_array (
        .clk_i, .arst_n_i,
        .acc_valid_i (acc_valid), .acc_addr1_i (acc_addr1), .acc_addr2_i (acc_addr2),
        .acc_size_i  (acc_size),
        .wb_valid_i, .wb_addr_i, .wb_data_i, .wb_size_i,
        .rd_valid_o  (rd_valid),  .rd_data1_o  (rd_data1),  .rd_data2_o  (rd_data2)
    );

    operand_select u_operand_select (
        .clk_i, .arst_n_i,
        .acc_valid_i (acc_valid), .acc_last_i  (acc_last),  .acc_addr1_i (acc_addr1),
        .acc_reg_i   (acc_reg),   .acc_imm_i   (acc_imm),   .acc_eip_i   (acc_eip),
        .acc_sel1_i  (acc_sel1),  .acc_sel2_i  (acc_sel2),
        .rd_valid_i  (rd_valid),  .rd_data1_i  (rd_data1),  .rd_data2_i  (rd_data2),
        .valid_o, .op1_val_o, .op2_val_o, .dest_addr_o, .last_o
    );

endmodule

`default_nettype wire

// File: tests/mem_stage_props.sv
`default_nettype none

module mem_stage_props import core_pkg::*, mem_pkg::*; (
    input wire logic              clk_i,
    input wire logic              arst_n_i,
    input wire logic              valid_i,
    input wire logic              is_rep_i,
    input wire logic [ADDR_W-1:0] rep_cnt_i,
    input wire logic              busy_o,
    input wire logic              valid_o
);

    int fail_cnt = 0;

    logic single_acc;

    assign single_acc = valid_i && (!is_rep_i || rep_cnt_i == ADDR_W'(1));

    // upstream holds off while a repeat is issuing
    a_no_strobe_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_o |-> !valid_i)
        else begin
            $error("instruction strobed while busy_o was high");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !valid_o)
        else begin
            $error("valid_o high during reset");
            fail_cnt++;
        end

    a_single_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        single_acc |-> ##STAGE_LAT valid_o)
        else begin
            $error("single access result not seen after the stage latency");
            fail_cnt++;
        end

    a_single_no_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && !(is_rep_i && rep_cnt_i > ADDR_W'(1)) |=> !busy_o)
        else begin
            $error("busy_o raised for an instruction with one access or none");
            fail_cnt++;
        end

endmodule

bind mem_stage_top mem_stage_props u_mem_stage_props (.*);

`default_nettype wire

// File: tests/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb import core_pkg::*, mem_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // cycle budget per test, in run order
    localparam int TEST_CYCLES   = 200 + 100 + 40 + 400 + 40 + 80;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + 2000;

    logic              clk;
    logic              arst_n;
    logic              valid;
    opsize_e           opsize;
    logic              df;
    logic              is_rep;
    logic [ADDR_W-1:0] rep_cnt;
    logic [ADDR_W-1:0] addr1;
    logic [ADDR_W-1:0] addr2;
    logic [DATA_W-1:0] reg_val;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] eip;
    opnd_sel_e         sel1;
    opnd_sel_e         sel2;
    logic              wb_valid;
    logic [ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0] wb_data;
    opsize_e           wb_size;
    logic              busy;
    logic              res_valid;
    logic [DATA_W-1:0] op1_val;
    logic [DATA_W-1:0] op2_val;
    logic [ADDR_W-1:0] dest_addr;
    logic              last;

    logic [7:0]        model [MEM_BYTES];  // byte image kept by our own writebacks
    logic [DATA_W-1:0] exp_op1_q[$];
    logic [DATA_W-1:0] exp_op2_q[$];
    logic [ADDR_W-1:0] exp_addr_q[$];
    logic              exp_last_q[$];
    logic              exp_avail;
    logic [DATA_W-1:0] head_op1;
    logic [DATA_W-1:0] head_op2;
    logic [ADDR_W-1:0] head_addr;
    logic              head_last;
    int                busy_left;
    int                errors;
    int                mark;
    int                tests_run;
    logic [31:0]       lfsr;

    mem_stage_top u_mem_stage_top (
        .clk_i (clk), .arst_n_i (arst_n), .valid_i (valid), .opsize_i (opsize),
        .df_i (df), .is_rep_i (is_rep), .rep_cnt_i (rep_cnt),
        .mem_addr1_i (addr1), .mem_addr2_i (addr2), .reg_val_i (reg_val),
        .imm_i (imm), .eip_i (eip), .op1_sel_i (sel1), .op2_sel_i (sel2),
        .wb_valid_i (wb_valid), .wb_addr_i (wb_addr), .wb_data_i (wb_data),
        .wb_size_i (wb_size), .busy_o (busy), .valid_o (res_valid),
        .op1_val_o (op1_val), .op2_val_o (op2_val), .dest_addr_o (dest_addr),
        .last_o (last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [DATA_W-1:0] rand_bits(input int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int size_bytes(input opsize_e sz);
        case (sz)
            SZ_BYTE: return 1;
            SZ_WORD: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr,
                                                     input opsize_e sz);
        logic [DATA_W-1:0]    data;
        logic [MEM_IDX_W-1:0] idx;
        data = '0;
        for (int b = 0; b < size_bytes(sz); b++) begin
            idx = addr[MEM_IDX_W-1:0] + MEM_IDX_W'(b);
            data[8*b +: 8] = model[idx];
        end
        return data;
    endfunction

    function automatic logic [DATA_W-1:0] operand_source(
        input opnd_sel_e sel, input logic [DATA_W-1:0] r, input logic [DATA_W-1:0] m1,
        input logic [DATA_W-1:0] m2, input logic [DATA_W-1:0] i, input logic [DATA_W-1:0] e
    );
        case (sel)
            SEL_MEM1: return m1;
            SEL_MEM2: return m2;
            SEL_IMM:  return i;
            SEL_EIP:  return e;
            default:  return r;
        endcase
    endfunction

    function automatic void refresh_head();
        exp_avail = (exp_op1_q.size() != 0);
        if (exp_avail) begin
            head_op1  = exp_op1_q[0];
            head_op2  = exp_op2_q[0];
            head_addr = exp_addr_q[0];
            head_last = exp_last_q[0];
        end
    endfunction

    function automatic int error_total();
        return errors + u_mem_stage_top.u_mem_stage_props.fail_cnt;
    endfunction

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input opsize_e sz);
        logic [MEM_IDX_W-1:0] idx;
        wb_valid = 1'b1;
        wb_addr  = addr;
        wb_data  = data;
        wb_size  = sz;
        for (int b = 0; b < size_bytes(sz); b++) begin
            idx = addr[MEM_IDX_W-1:0] + MEM_IDX_W'(b);
            model[idx] = data[8*b +: 8];
        end
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic issue(input opsize_e sz, input logic dir, input logic rep, input int cnt,
                         input logic [ADDR_W-1:0] a1, input logic [ADDR_W-1:0] a2,
                         input opnd_sel_e s1, input opnd_sel_e s2);
        int                n;
        logic [ADDR_W-1:0] step;
        logic [ADDR_W-1:0] e1;
        logic [ADDR_W-1:0] e2;
        logic [DATA_W-1:0] m1;
        logic [DATA_W-1:0] m2;
        n = rep ? cnt : 1;
        step = dir ? -ADDR_W'(size_bytes(sz)) : ADDR_W'(size_bytes(sz));
        reg_val = rand_bits(32);
        imm     = rand_bits(32);
        eip     = rand_bits(32);
        for (int i = 0; i < n; i++) begin
            e1 = a1 + step * ADDR_W'(i);
            e2 = a2 + step * ADDR_W'(i);
            m1 = model_read(e1, sz);
            m2 = model_read(e2, sz);
            exp_op1_q.push_back(operand_source(s1, reg_val, m1, m2, imm, eip));
            exp_op2_q.push_back(operand_source(s2, reg_val, m1, m2, imm, eip));
            exp_addr_q.push_back(e1);
            exp_last_q.push_back(i == n - 1);
        end
        refresh_head();
        valid   = 1'b1;
        opsize  = sz;
        df      = dir;
        is_rep  = rep;
        rep_cnt = ADDR_W'(cnt);
        addr1   = a1;
        addr2   = a2;
        sel1    = s1;
        sel2    = s2;
        @(posedge clk);
        #1;
        valid = 1'b0;
        // results drain within the stage latency plus one cycle per element
        for (int w = 0; w < n + STAGE_LAT && exp_op1_q.size() != 0; w++) begin
            @(posedge clk);
            #1;
        end
        if (n == 0) begin
            repeat (STAGE_LAT + 1) @(posedge clk);  // room for a stray result to show
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        if (exp_op1_q.size() != 0) begin
            $display("%s: %0d expected results never arrived", name, exp_op1_q.size());
            errors++;
            exp_op1_q.delete();
            exp_op2_q.delete();
            exp_addr_q.delete();
            exp_last_q.delete();
            refresh_head();
        end
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, error_total() - mark);
        mark = error_total();
    endtask

    // busy expected once per element of a multi element repeat
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_left <= 0;
        end else if (valid) begin
            busy_left <= (is_rep && rep_cnt > 1) ? int'(rep_cnt) : 0;
        end else if (busy_left != 0) begin
            busy_left <= busy_left - 1;
        end
    end

    always @(posedge clk) begin
        if (arst_n && res_valid && exp_avail) begin
            void'(exp_op1_q.pop_front());
            void'(exp_op2_q.pop_front());
            void'(exp_addr_q.pop_front());
            void'(exp_last_q.pop_front());
            refresh_head();
        end
    end

    a_expected: assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> exp_avail)
        else begin
            $display("valid_o raised with no result expected");
            errors++;
        end
    a_op1: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && exp_avail |-> op1_val == head_op1)
        else begin
            $display("Mismatch op1_val_o: expected %h, got %h", $sampled(head_op1),
                     $sampled(op1_val));
            errors++;
        end
    a_op2: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && exp_avail |-> op2_val == head_op2)
        else begin
            $display("Mismatch op2_val_o: expected %h, got %h", $sampled(head_op2),
                     $sampled(op2_val));
            errors++;
        end
    a_dest: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && exp_avail |-> dest_addr == head_addr)
        else begin
            $display("Mismatch dest_addr_o: expected %h, got %h", $sampled(head_addr),
                     $sampled(dest_addr));
            errors++;
        end
    a_last: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && exp_avail |-> last == head_last)
        else begin
            $display("Mismatch last_o: expected %h, got %h", $sampled(head_last),
                     $sampled(last));
            errors++;
        end
    a_busy: assert property (@(posedge clk) disable iff (!arst_n) busy == (busy_left != 0))
        else begin
            $display("Mismatch busy_o: expected %h, got %h", $sampled(busy_left != 0),
                     $sampled(busy));
            errors++;
        end
    a_burst: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !last |=> res_valid)
        else begin
            $display("repeat results stopped before the last element");
            errors++;
        end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: run went past %0d time units", WATCHDOG_TIME);
        $display("Test failures found");
        $finish;
    end

    initial begin
        opsize_e           sz;
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        opnd_sel_e         s1;
        opnd_sel_e         s2;
        lfsr      = 32'd72;
        errors    = 0;
        mark      = 0;
        tests_run = 0;
        exp_avail = 1'b0;
        arst_n    = 1'b1;
        valid     = 1'b0;
        opsize    = SZ_BYTE;
        df        = 1'b0;
        is_rep    = 1'b0;
        rep_cnt   = '0;
        addr1     = '0;
        addr2     = '0;
        reg_val   = '0;
        imm       = '0;
        eip       = '0;
        sel1      = SEL_REG;
        sel2      = SEL_REG;
        wb_valid  = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        wb_size   = SZ_BYTE;
        #1 arst_n = 1'b0;  // clean falling edge for the async reset
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;

        for (int a = 0; a < MEM_BYTES; a += 4) begin
            wb_write(ADDR_W'(a), rand_bits(32), SZ_DWORD);
        end
        for (int i = 0; i < 12; i++) begin
            sz = opsize_e'(2'(rand_bits(2) % 3));
            a1 = rand_bits(32);
            a2 = rand_bits(32);
            wb_write(a1, rand_bits(32), sz);
            wb_write(a2, rand_bits(32), sz);
            issue(sz, 1'b0, 1'b0, 0, a1, a2, SEL_MEM1, SEL_MEM2);
        end
        finish_test("writeback then read");

        for (int i = 0; i < 10; i++) begin
            sz = opsize_e'(2'(rand_bits(2) % 3));
            s1 = opnd_sel_e'(3'(rand_bits(3) % 5));
            s2 = opnd_sel_e'(3'(rand_bits(3) % 5));
            issue(sz, 1'b0, 1'b0, 0, rand_bits(32), rand_bits(32), s1, s2);
        end
        finish_test("operand select");

        // count is ignored without the repeat prefix
        for (int i = 0; i < 4; i++) begin
            issue(SZ_DWORD, i[0], 1'b0, 1 + 3 * i, rand_bits(32), rand_bits(32),
                  SEL_MEM1, SEL_IMM);
        end
        finish_test("fixed latency");

        for (int s = 0; s < 3; s++) begin
            for (int d = 0; d < 2; d++) begin
                for (int c = 1; c <= 6; c++) begin
                    issue(opsize_e'(s), d[0], 1'b1, c, rand_bits(32), rand_bits(32),
                          SEL_MEM1, SEL_MEM2);
                end
            end
        end
        finish_test("repeat up and down");

        for (int i = 0; i < 3; i++) begin
            issue(SZ_WORD, i[0], 1'b1, 0, rand_bits(32), rand_bits(32), SEL_REG, SEL_IMM);
        end
        finish_test("zero count");

        wb_write(32'd254, rand_bits(32), SZ_DWORD);
        issue(SZ_DWORD, 1'b0, 1'b0, 0, 32'd254, 32'd255, SEL_MEM1, SEL_MEM2);
        issue(SZ_WORD, 1'b0, 1'b0, 0, 32'h0000_01ff, 32'd253, SEL_MEM1, SEL_MEM2);
        issue(SZ_DWORD, 1'b0, 1'b1, 4, 32'd250, 32'd3, SEL_MEM1, SEL_MEM2);
        issue(SZ_WORD, 1'b1, 1'b1, 3, 32'd2, 32'd255, SEL_MEM1, SEL_MEM2);
        finish_test("address wrap");

        $display("tests run: %0d, errors: %0d", tests_run, error_total());
        if (error_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/core_pkg.sv
design/mem_pkg.sv
design/rep_addr_gen.sv
design/dmem_array.sv
design/operand_select.sv
design/mem_stage_top.sv
tests/mem_stage_props.sv
tests/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - design/core_pkg.sv
      - design/mem_pkg.sv
      - design/rep_addr_gen.sv
      - design/dmem_array.sv
      - design/operand_select.sv
      - design/mem_stage_top.sv
  - target: test
    files:
      - tests/mem_stage_props.sv
      - tests/mem_stage_tb.sv
